// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN     = 64;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [63:0]     pc_t;
    typedef logic [31:0]     count_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    // Decoded bundle as it arrives at issue
    typedef struct packed {
        pc_t      pc;
        logic     is_mul;
        alu_op_t  alu_op;
        reg_idx_t dst;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        logic     use_imm;
        logic     wb_en;
    } issue_req_t;

    // Operation with resolved operands, shared by both units
    typedef struct packed {
        pc_t      pc;
        alu_op_t  alu_op;
        reg_idx_t dst;
        logic     wb_en;
        xlen_t    operand1;
        xlen_t    operand2;
    } exec_req_t;

    // Completed result on its way to the register file
    typedef struct packed {
        pc_t      pc;
        reg_idx_t dst;
        logic     wb_en;
        xlen_t    result;
    } wb_rec_t;

endpackage

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire reg_idx_t raddr0,
    output xlen_t         rdata0,
    input  wire reg_idx_t raddr1,
    output xlen_t         rdata1,
    input  wire           wen0,
    input  wire reg_idx_t waddr0,
    input  wire xlen_t    wdata0,
    input  wire           wen1,
    input  wire reg_idx_t waddr1,
    input  wire xlen_t    wdata1
);

    xlen_t regs [NUM_REGS];

    // Port 1 is applied last, though WAW stalls keep the ports apart
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen0 && (waddr0 != '0)) begin
                regs[waddr0] <= wdata0;
            end
            if (wen1 && (waddr1 != '0)) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    // No write-to-read bypass here, issue forwards instead
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

`default_nettype wire

// File: issue/issue_unit.sv
`timescale 1ns/1ps
`default_nettype none

module issue_unit
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    // Bundle input
    input  wire issue_req_t in_req,
    input  wire             in_valid,
    output logic            in_ready,
    // Register file read ports
    output reg_idx_t        raddr0,
    input  wire xlen_t      rdata0,
    output reg_idx_t        raddr1,
    input  wire xlen_t      rdata1,
    // To integer pipe
    output exec_req_t       ip_req,
    output logic            ip_valid,
    // To multiply unit
    output exec_req_t       mul_req,
    output logic            mul_valid,
    input  wire             mul_ready,
    // Results being written back
    input  wire wb_rec_t    wb0,
    input  wire             wb0_valid,
    input  wire wb_rec_t    wb1,
    input  wire             wb1_valid
);

    logic [NUM_REGS-1:0] busy;
    logic [NUM_REGS-1:0] clr_mask;
    logic [NUM_REGS-1:0] set_mask;
    logic [NUM_REGS-1:0] pending;
    logic                src_hazard;
    logic                dst_hazard;
    logic                fire;
    xlen_t               opr1;
    xlen_t               opr2;
    exec_req_t           req;

    function automatic logic fwd_hit(input wb_rec_t rec, input logic vld, input reg_idx_t idx);
        return vld && rec.wb_en && (rec.dst == idx) && (idx != '0);
    endfunction

    assign raddr0 = in_req.rs1;
    assign raddr1 = in_req.rs2;

    // Registers whose value lands on a writeback record this cycle
    always_comb begin
        clr_mask = '0;
        if (wb0_valid && wb0.wb_en) begin
            clr_mask[wb0.dst] = 1'b1;
        end
        if (wb1_valid && wb1.wb_en) begin
            clr_mask[wb1.dst] = 1'b1;
        end
    end

    // Busy and not forwardable right now
    assign pending = busy & ~clr_mask;

    assign src_hazard = pending[in_req.rs1] || (!in_req.use_imm && pending[in_req.rs2]);
    assign dst_hazard = in_req.wb_en && pending[in_req.dst];
    assign in_ready   = !src_hazard && !dst_hazard && (!in_req.is_mul || mul_ready);
    assign fire       = in_valid && in_ready;

    // Operand select, wb0 has priority over wb1
    always_comb begin
        opr1 = rdata0;
        if (fwd_hit(wb1, wb1_valid, in_req.rs1)) begin
            opr1 = wb1.result;
        end
        if (fwd_hit(wb0, wb0_valid, in_req.rs1)) begin
            opr1 = wb0.result;
        end

        opr2 = rdata1;
        if (fwd_hit(wb1, wb1_valid, in_req.rs2)) begin
            opr2 = wb1.result;
        end
        if (fwd_hit(wb0, wb0_valid, in_req.rs2)) begin
            opr2 = wb0.result;
        end
        if (in_req.use_imm) begin
            opr2 = in_req.imm;
        end
    end

    always_comb begin
        req.pc       = in_req.pc;
        req.alu_op   = in_req.alu_op;
        req.dst      = in_req.dst;
        req.wb_en    = in_req.wb_en;
        req.operand1 = opr1;
        req.operand2 = opr2;
    end

    assign ip_req    = req;
    assign mul_req   = req;
    assign ip_valid  = fire && !in_req.is_mul;
    assign mul_valid = fire && in_req.is_mul;

    // x0 never becomes busy
    always_comb begin
        set_mask = '0;
        if (fire && in_req.wb_en && (in_req.dst != '0)) begin
            set_mask[in_req.dst] = 1'b1;
        end
    end

    // Scoreboard, a new claim wins over a clear of the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~clr_mask) | set_mask;
        end
    end

endmodule

`default_nettype wire

// File: hw/int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module int_pipe
    import core_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    // From issue
    input  wire exec_req_t ip_req,
    input  wire            ip_valid,
    // To writeback
    output wb_rec_t        ip_res,
    output logic           ip_res_valid
);

    xlen_t      op1;
    xlen_t      op2;
    logic [5:0] shamt;
    xlen_t      alu_out;

    assign op1   = ip_req.operand1;
    assign op2   = ip_req.operand2;
    assign shamt = op2[5:0];

    always_comb begin
        case (ip_req.alu_op)
            ALU_ADD:  alu_out = op1 + op2;
            ALU_SUB:  alu_out = op1 - op2;
            ALU_AND:  alu_out = op1 & op2;
            ALU_OR:   alu_out = op1 | op2;
            ALU_XOR:  alu_out = op1 ^ op2;
            ALU_SLL:  alu_out = op1 << shamt;
            ALU_SRL:  alu_out = op1 >> shamt;
            ALU_SRA:  alu_out = xlen_t'($signed(op1) >>> shamt);
            ALU_SLT:  alu_out = xlen_t'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_out = xlen_t'(op1 < op2);
            default:  alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ip_res_valid <= 1'b0;
        end else begin
            ip_res_valid <= ip_valid;
        end
    end

    // Result payload, only loaded on a dispatch
    always_ff @(posedge clk) begin
        if (ip_valid) begin
            ip_res.pc     <= ip_req.pc;
            ip_res.dst    <= ip_req.dst;
            ip_res.wb_en  <= ip_req.wb_en;
            ip_res.result <= alu_out;
        end
    end

endmodule

`default_nettype wire

// File: mul/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import core_pkg::*;
#(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  wire            clk,
    input  wire            rst,
    // From issue
    input  wire exec_req_t mul_req,
    input  wire            mul_valid,
    output logic           mul_ready,
    // To writeback
    output wb_rec_t        mul_res,
    output logic           mul_res_valid
);

    localparam int MUL_STEPS = XLEN / MUL_BITS_PER_CYCLE;
    localparam int CNT_W     = $clog2(MUL_STEPS);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_t;

    mul_state_t state;
    logic [CNT_W-1:0] step_cnt;
    pc_t      pc_q;
    reg_idx_t dst_q;
    logic     wb_en_q;
    xlen_t    mcand_q;
    xlen_t    mplr_q;
    xlen_t    acc_q;
    xlen_t    acc_next;

    // Add the shifted multiplicand for each multiplier bit retired this step
    always_comb begin
        acc_next = acc_q;
        for (int j = 0; j < MUL_BITS_PER_CYCLE; j++) begin
            if (mplr_q[j]) begin
                acc_next = acc_next + (mcand_q << j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= MUL_IDLE;
            mul_res_valid <= 1'b0;
        end else begin
            mul_res_valid <= 1'b0;
            case (state)
                MUL_IDLE: if (mul_valid) state <= MUL_RUN;
                MUL_RUN:  if (step_cnt == CNT_W'(MUL_STEPS - 1)) state <= MUL_DONE;
                MUL_DONE: begin
                    mul_res_valid <= 1'b1;
                    state         <= MUL_IDLE;
                end
                default:  state <= MUL_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if ((state == MUL_IDLE) && mul_valid) begin
            pc_q     <= mul_req.pc;
            dst_q    <= mul_req.dst;
            wb_en_q  <= mul_req.wb_en;
            mcand_q  <= mul_req.operand1;
            mplr_q   <= mul_req.operand2;
            acc_q    <= '0;
            step_cnt <= '0;
        end else if (state == MUL_RUN) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_q << MUL_BITS_PER_CYCLE;
            mplr_q   <= mplr_q >> MUL_BITS_PER_CYCLE;
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assign mul_ready = (state == MUL_IDLE);

    // Held until the next request is taken
    assign mul_res.pc     = pc_q;
    assign mul_res.dst    = dst_q;
    assign mul_res.wb_en  = wb_en_q;
    assign mul_res.result = acc_q;

endmodule

`default_nettype wire

// File: hw/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback
    import core_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    // From the units
    input  wire wb_rec_t ip_res,
    input  wire          ip_res_valid,
    input  wire wb_rec_t mul_res,
    input  wire          mul_res_valid,
    // Register file write ports
    output logic         wen0,
    output reg_idx_t     waddr0,
    output xlen_t        wdata0,
    output logic         wen1,
    output reg_idx_t     waddr1,
    output xlen_t        wdata1,
    // Forwarding back to issue
    output wb_rec_t      wb0,
    output logic         wb0_valid,
    output wb_rec_t      wb1,
    output logic         wb1_valid,
    // Commit records
    output wb_rec_t      commit0,
    output logic         commit0_valid,
    output wb_rec_t      commit1,
    output logic         commit1_valid,
    output count_t       instret
);

    // Integer pipe on port 0, multiply on port 1
    assign wen0   = ip_res_valid && ip_res.wb_en;
    assign waddr0 = ip_res.dst;
    assign wdata0 = ip_res.result;
    assign wen1   = mul_res_valid && mul_res.wb_en;
    assign waddr1 = mul_res.dst;
    assign wdata1 = mul_res.result;

    assign wb0       = ip_res;
    assign wb0_valid = ip_res_valid;
    assign wb1       = mul_res;
    assign wb1_valid = mul_res_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit0_valid <= 1'b0;
            commit1_valid <= 1'b0;
            instret       <= '0;
        end else begin
            commit0_valid <= ip_res_valid;
            commit1_valid <= mul_res_valid;
            // Counts the commits presented in the previous cycle
            instret       <= instret + count_t'(commit0_valid) + count_t'(commit1_valid);
        end
    end

    always_ff @(posedge clk) begin
        commit0 <= ip_res;
        commit1 <= mul_res;
    end

endmodule

`default_nettype wire

// File: hw/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core
    import core_pkg::*;
#(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  wire             clk,
    input  wire             rst,
    input  wire issue_req_t in_req,
    input  wire             in_valid,
    output wire             in_ready,
    output wire wb_rec_t    commit0,
    output wire             commit0_valid,
    output wire wb_rec_t    commit1,
    output wire             commit1_valid,
    output wire count_t     instret
);

    // Register file
    wire reg_idx_t rf_raddr0;
    wire reg_idx_t rf_raddr1;
    wire xlen_t    rf_rdata0;
    wire xlen_t    rf_rdata1;
    wire           rf_wen0;
    wire           rf_wen1;
    wire reg_idx_t rf_waddr0;
    wire reg_idx_t rf_waddr1;
    wire xlen_t    rf_wdata0;
    wire xlen_t    rf_wdata1;

    // Issue to units
    wire exec_req_t ip_req;
    wire            ip_valid;
    wire exec_req_t mul_req;
    wire            mul_valid;
    wire            mul_ready;

    // Units to writeback, and forwarding
    wire wb_rec_t ip_res;
    wire          ip_res_valid;
    wire wb_rec_t mul_res;
    wire          mul_res_valid;
    wire wb_rec_t wb0;
    wire          wb0_valid;
    wire wb_rec_t wb1;
    wire          wb1_valid;

    reg_file u_reg_file (
        .clk    (clk),
        .rst    (rst),
        .raddr0 (rf_raddr0),
        .rdata0 (rf_rdata0),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .wen0   (rf_wen0),
        .waddr0 (rf_waddr0),
        .wdata0 (rf_wdata0),
        .wen1   (rf_wen1),
        .waddr1 (rf_waddr1),
        .wdata1 (rf_wdata1)
    );

    issue_unit u_issue_unit (
        .clk       (clk),
        .rst       (rst),
        .in_req    (in_req),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .raddr0    (rf_raddr0),
        .rdata0    (rf_rdata0),
        .raddr1    (rf_raddr1),
        .rdata1    (rf_rdata1),
        .ip_req    (ip_req),
        .ip_valid  (ip_valid),
        .mul_req   (mul_req),
        .mul_valid (mul_valid),
        .mul_ready (mul_ready),
        .wb0       (wb0),
        .wb0_valid (wb0_valid),
        .wb1       (wb1),
        .wb1_valid (wb1_valid)
    );

    int_pipe u_int_pipe (
        .clk          (clk),
        .rst          (rst),
        .ip_req       (ip_req),
        .ip_valid     (ip_valid),
        .ip_res       (ip_res),
        .ip_res_valid (ip_res_valid)
    );

    mul_unit #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_mul_unit (
        .clk           (clk),
        .rst           (rst),
        .mul_req       (mul_req),
        .mul_valid     (mul_valid),
        .mul_ready     (mul_ready),
        .mul_res       (mul_res),
        .mul_res_valid (mul_res_valid)
    );

    writeback u_writeback (
        .clk           (clk),
        .rst           (rst),
        .ip_res        (ip_res),
        .ip_res_valid  (ip_res_valid),
        .mul_res       (mul_res),
        .mul_res_valid (mul_res_valid),
        .wen0          (rf_wen0),
        .waddr0        (rf_waddr0),
        .wdata0        (rf_wdata0),
        .wen1          (rf_wen1),
        .waddr1        (rf_waddr1),
        .wdata1        (rf_wdata1),
        .wb0           (wb0),
        .wb0_valid     (wb0_valid),
        .wb1           (wb1),
        .wb1_valid     (wb1_valid),
        .commit0       (commit0),
        .commit0_valid (commit0_valid),
        .commit1       (commit1),
        .commit1_valid (commit1_valid),
        .instret       (instret)
    );

endmodule

`default_nettype wire

// File: testbench/exec_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_chk
    import core_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input wire wb_rec_t commit0,
    input wire          commit0_valid,
    input wire wb_rec_t commit1,
    input wire          commit1_valid,
    input wire count_t  instret
);

    int unsigned fail_count = 0;

    // Commit outputs come out of reset quiet
    no_commit_after_reset: assert property (@(posedge clk)
        rst |=> !commit0_valid && !commit1_valid)
        else begin
            $error("commit valid in the cycle after reset");
            fail_count++;
        end

    // WAW stalls keep the two ports off the same register
    distinct_commit_dst: assert property (@(posedge clk) disable iff (rst)
        (commit0_valid && commit1_valid && commit0.wb_en && commit1.wb_en
         && (commit0.dst != '0)) |-> (commit0.dst != commit1.dst))
        else begin
            $error("both commit ports wrote register x%0d", commit0.dst);
            fail_count++;
        end

    instret_tracks_commits: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> (instret == $past(instret) + count_t'($past(commit0_valid))
                  + count_t'($past(commit1_valid))))
        else begin
            $error("instret did not follow the commit count");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: testbench/exec_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb
    import core_pkg::*;
;

    localparam int MUL_BITS_PER_CYCLE = 4;
    localparam int MUL_STEPS          = XLEN / MUL_BITS_PER_CYCLE;
    localparam int NUM_ENTRIES        = 24;
    localparam int CLK_PERIOD         = 4;
    localparam int TIMEOUT_CYCLES     = NUM_ENTRIES * (MUL_STEPS + 8) + 50;

    logic       clk;
    logic       rst;
    issue_req_t in_req;
    logic       in_valid;
    wire        in_ready;
    wb_rec_t    commit0;
    wire        commit0_valid;
    wb_rec_t    commit1;
    wire        commit1_valid;
    count_t     instret;

    // Instruction table and expected results
    issue_req_t req_tab    [NUM_ENTRIES];
    xlen_t      exp_tab    [NUM_ENTRIES];
    string      name_tab   [NUM_ENTRIES];
    bit         done_tab   [NUM_ENTRIES];
    bit         no_gap_tab [NUM_ENTRIES];
    int         n_loaded     = 0;
    int         commit_count = 0;
    int         pass_count   = 0;
    int         err_count    = 0;
    logic [15:0] lfsr        = 16'd88;

    exec_core #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .in_req        (in_req),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .commit0       (commit0),
        .commit0_valid (commit0_valid),
        .commit1       (commit1),
        .commit1_valid (commit1_valid),
        .instret       (instret)
    );

    bind exec_core exec_core_chk u_chk (
        .clk           (clk),
        .rst           (rst),
        .commit0       (commit0),
        .commit0_valid (commit0_valid),
        .commit1       (commit1),
        .commit1_valid (commit1_valid),
        .instret       (instret)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic add_entry(input string name, input logic is_mul, input alu_op_t op,
                             input reg_idx_t dst, input reg_idx_t rs1, input reg_idx_t rs2,
                             input xlen_t imm, input logic use_imm, input xlen_t expect_val);
        issue_req_t r;
        r.pc       = pc_t'(n_loaded * 4);
        r.is_mul   = is_mul;
        r.alu_op   = op;
        r.dst      = dst;
        r.rs1      = rs1;
        r.rs2      = rs2;
        r.imm      = imm;
        r.use_imm  = use_imm;
        r.wb_en    = 1'b1;
        req_tab[n_loaded]    = r;
        exp_tab[n_loaded]    = expect_val;
        name_tab[n_loaded]   = name;
        done_tab[n_loaded]   = 1'b0;
        no_gap_tab[n_loaded] = 1'b0;
        n_loaded++;
    endtask

    task automatic load_table();
        add_entry("addi x1,x0,100",  0, ALU_ADD,  1,  0,  0, 64'd100, 1, 64'h64);
        add_entry("addi x2,x0,-7",   0, ALU_ADD,  2,  0,  0, 64'hFFFF_FFFF_FFFF_FFF9, 1,
                  64'hFFFF_FFFF_FFFF_FFF9);
        add_entry("add x3,x1,x2",    0, ALU_ADD,  3,  1,  2, 64'd0,   0, 64'h5D);
        add_entry("sub x4,x1,x2",    0, ALU_SUB,  4,  1,  2, 64'd0,   0, 64'h6B);
        add_entry("andi x5,x1,0x3c", 0, ALU_AND,  5,  1,  0, 64'h3C,  1, 64'h24);
        add_entry("or x6,x1,x2",     0, ALU_OR,   6,  1,  2, 64'd0,   0,
                  64'hFFFF_FFFF_FFFF_FFFD);
        add_entry("xori x7,x3,0xff", 0, ALU_XOR,  7,  3,  0, 64'hFF,  1, 64'hA2);
        add_entry("slli x8,x1,4",    0, ALU_SLL,  8,  1,  0, 64'd4,   1, 64'h640);
        add_entry("srli x9,x2,60",   0, ALU_SRL,  9,  2,  0, 64'd60,  1, 64'hF);
        add_entry("srai x10,x2,1",   0, ALU_SRA,  10, 2,  0, 64'd1,   1,
                  64'hFFFF_FFFF_FFFF_FFFC);
        add_entry("slt x11,x2,x1",   0, ALU_SLT,  11, 2,  1, 64'd0,   0, 64'h1);
        add_entry("sltu x12,x2,x1",  0, ALU_SLTU, 12, 2,  1, 64'd0,   0, 64'h0);
        // Result still commits, but x0 keeps reading zero
        add_entry("addi x0,x1,5",    0, ALU_ADD,  0,  1,  0, 64'd5,   1, 64'h69);
        add_entry("add x13,x0,x1",   0, ALU_ADD,  13, 0,  1, 64'd0,   0, 64'h64);
        add_entry("mul x14,x1,x2",   1, ALU_ADD,  14, 1,  2, 64'd0,   0,
                  64'hFFFF_FFFF_FFFF_FD44);
        add_entry("addi x15,x3,1",   0, ALU_ADD,  15, 3,  0, 64'd1,   1, 64'h5E);
        add_entry("mul x16,x2,x2",   1, ALU_ADD,  16, 2,  2, 64'd0,   0, 64'h31);
        add_entry("add x17,x14,x1",  0, ALU_ADD,  17, 14, 1, 64'd0,   0,
                  64'hFFFF_FFFF_FFFF_FDA8);
        add_entry("mul x18,x17,x2",  1, ALU_ADD,  18, 17, 2, 64'd0,   0, 64'h1068);
        add_entry("sub x19,x18,x16", 0, ALU_SUB,  19, 18, 16, 64'd0,  0, 64'h1037);
        add_entry("andi x20,x19,0xf0", 0, ALU_AND, 20, 19, 0, 64'hF0, 1, 64'h30);
        add_entry("muli x21,x20,16", 1, ALU_ADD,  21, 20, 0, 64'h10,  1, 64'h300);
        add_entry("add x22,x21,x21", 0, ALU_ADD,  22, 21, 21, 64'd0,  0, 64'h600);
        add_entry("sll x23,x22,x9",  0, ALU_SLL,  23, 22, 9, 64'd0,   0, 64'h300_0000);
        // Dependent bundles sent with no gap, so their sources come from writeback
        no_gap_tab[2]  = 1'b1;
        no_gap_tab[13] = 1'b1;
        no_gap_tab[20] = 1'b1;
        no_gap_tab[21] = 1'b1;
        no_gap_tab[23] = 1'b1;
    endtask

    task automatic check_commit(input wb_rec_t rec, input int port);
        int idx;
        bit good;
        if (rec.pc[1:0] != 2'b00 || rec.pc >= pc_t'(NUM_ENTRIES * 4)) begin
            $display("Commit on port %0d has pc 0x%h, which is not in the table", port, rec.pc);
            err_count++;
        end else begin
            idx = int'(rec.pc >> 2);
            if (done_tab[idx]) begin
                $display("Entry %0d (%s) committed more than once", idx, name_tab[idx]);
                err_count++;
            end else begin
                done_tab[idx] = 1'b1;
                commit_count++;
                good = 1'b1;
                if (port != int'(req_tab[idx].is_mul)) begin
                    $display("Entry %0d (%s) committed on the wrong port %0d",
                             idx, name_tab[idx], port);
                    good = 1'b0;
                end
                assert (rec.dst === req_tab[idx].dst) else begin
                    good = 1'b0;
                    $display("Error: %s dst expected x%0d actual x%0d",
                             name_tab[idx], req_tab[idx].dst, rec.dst);
                end
                assert (rec.wb_en === req_tab[idx].wb_en) else begin
                    good = 1'b0;
                    $display("Error: %s wb_en expected %0b actual %0b",
                             name_tab[idx], req_tab[idx].wb_en, rec.wb_en);
                end
                assert (rec.result === exp_tab[idx]) else begin
                    good = 1'b0;
                    $display("Error: %s expected 0x%h actual 0x%h",
                             name_tab[idx], exp_tab[idx], rec.result);
                end
                if (good) begin
                    pass_count++;
                    $display("ok     %s result 0x%h", name_tab[idx], rec.result);
                end else begin
                    err_count++;
                end
            end
        end
    endtask

    // Commit outputs settle well before the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (commit0_valid) check_commit(commit0, 0);
            if (commit1_valid) check_commit(commit1, 1);
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: only %0d of %0d table entries committed, commits are missing",
                 commit_count, NUM_ENTRIES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int gap;
        in_req   = '0;
        in_valid = 1'b0;
        rst      = 1'b1;
        load_table();
        repeat (4) @(posedge clk);
        #0.5;
        rst = 1'b0;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            // Two LFSR bits give 0 to 3 idle cycles
            gap = 0;
            repeat (2) begin
                lfsr = lfsr_step(lfsr);
                gap  = (gap << 1) | int'(lfsr[0]);
            end
            if (no_gap_tab[i]) begin
                gap = 0;
            end
            in_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #0.5;
            end
            in_req   = req_tab[i];
            in_valid = 1'b1;
            @(negedge clk);
            while (!in_ready) @(negedge clk);
            @(posedge clk);
            #0.5;
        end
        in_valid = 1'b0;
        in_req   = '0;

        wait (commit_count == NUM_ENTRIES);
        // instret trails the commit outputs by a cycle
        repeat (2) @(negedge clk);
        assert (instret === count_t'(NUM_ENTRIES)) else begin
            err_count++;
            $display("Error: instret expected %0d actual %0d", NUM_ENTRIES, instret);
        end
        err_count = err_count + int'(dut.u_chk.fail_count);

        $display("Done: %0d passed, %0d errors", pass_count, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
common/core_pkg.sv
hw/reg_file.sv
issue/issue_unit.sv
hw/int_pipe.sv
mul/mul_unit.sv
hw/writeback.sv
hw/exec_core.sv
testbench/exec_core_chk.sv
testbench/exec_core_tb.sv

// File: Bender.yml
package:
  name: exec_core

sources:
  - files:
      - common/core_pkg.sv
      - hw/reg_file.sv
      - issue/issue_unit.sv
      - hw/int_pipe.sv
      - mul/mul_unit.sv
      - hw/writeback.sv
      - hw/exec_core.sv
  - target: test
    files:
      - testbench/exec_core_chk.sv
      - testbench/exec_core_tb.sv
